// ==== project.f ====
accel_pkg.sv
phi_sync.sv
access_decode.sv
fast_ram.sv
bus_sequencer.sv
beeb_accel_top.sv
tb_clock_gen.sv
tb_beeb_accel.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module tb_beeb_accel \
   -Mdir obj_dir -o sim_beeb_accel

./obj_dir/sim_beeb_accel > sim.log 2>&1
cat sim.log

if grep -q "TEST FAILED" sim.log; then
   exit 1
fi
exit 0

// ==== tb_beeb_accel.sv ====
// ------------------------------
// Accelerator testbench
// ------------------------------

`timescale 1ns/1ns

module tb_beeb_accel
   import accel_pkg::*;
();

   // Longest run is about 2000 cycles
   // External accesses take most of it
   localparam int timeout_cycles = 20000;

   logic     cpu_clk;
   logic     rst_n;
   logic     phi_in;
   logic     rdy;
   cpu_req_t cpu_req;
   data_t    bus_data_in;
   logic     cpu_clken;
   data_t    cpu_di;
   bus_out_t bus_out;
   logic     bus_data_oe;
   logic     phi1_out;
   logic     phi2_out;

   // Host memory, fast RAM and latch models
   data_t    host_mem [0:65535];
   data_t    ram_model [0:65535];
   logic     ram_valid [0:65535];
   logic     basic_m;
   logic     shadow_m;
   logic     vdu_op_m;
   // Access the DUT currently works on
   cpu_req_t cur_m;
   logic     cur_int_m;
   logic     cur_valid;

   int       errors;
   int       checks;
   int       cycles;
   int       phi_cnt;
   int       phi2_falls;
   int       rom_cycles;
   logic     phi_prev;
   logic     phi_prev2;
   logic     phi2_prev;
   logic     bus_seen;
   string    test_name;
   logic [31:0] lfsr;

   tb_clock_gen #(.period_ns(4), .reset_cycles(4)) clock_gen_i (
      .cpu_clk (cpu_clk),
      .rst_n   (rst_n)
   );

   beeb_accel_top #(
      .nphi0_regs    (6),
      .phiout_tap    (1),
      .ram_addr_bits (16)
   ) beeb_accel_top_i (
      .cpu_clk     (cpu_clk),
      .rst_n       (rst_n),
      .phi_in      (phi_in),
      .rdy         (rdy),
      .cpu_req     (cpu_req),
      .bus_data_in (bus_data_in),
      .cpu_clken   (cpu_clken),
      .cpu_di      (cpu_di),
      .bus_out     (bus_out),
      .bus_data_oe (bus_data_oe),
      .phi1_out    (phi1_out),
      .phi2_out    (phi2_out)
   );

   // ------------------------------
   // Reference model
   // ------------------------------

   // Host fill pattern depends on every address bit
   function automatic data_t fill_byte(addr_t a);
      return a[15:8] ^ {a[6:0], a[7]} ^ 8'hA5;
   endfunction

   // Routing rule for the next access
   function automatic logic route_internal(addr_t a);
      logic scr_ext;
      logic ext;
      scr_ext = shadow_m & vdu_op_m;
      ext = ((a[15:8] >= 8'h30) && (a[15:8] < 8'h80) && scr_ext) ||
            ((a[15:8] >= 8'h80) && (a[15:8] < 8'hC0) && !basic_m) ||
            ((a[15:8] >= 8'hFC) && (a[15:8] < 8'hFF));
      // Own shadow and speed latches never go out
      if ((a[15:2] == 14'h3F8D) || (a[15:2] == 14'h3F8E)) begin
         ext = 1'b0;
      end
      return !ext;
   endfunction

   function automatic logic ram_write_allowed(addr_t a);
      return !a[15] && ((a[15:8] < 8'h30) || !(shadow_m & vdu_op_m));
   endfunction

   // Expected read data for an access that completes now
   function automatic data_t predict_read(addr_t a, logic internal);
      return internal ? ram_model[a] : host_mem[a];
   endfunction

   task automatic expect_byte(string what, data_t exp, data_t act);
      checks++;
      assert (act === exp) else begin
         errors++;
         $display("[ERROR] %s: expected %02h, actual %02h", what, exp, act);
      end
   endtask

   task automatic report_fail(string msg);
      errors++;
      $display("Error in %s: %s", test_name, msg);
   endtask

   // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
   function automatic logic [15:0] next_bits(int n);
      logic        fb;
      logic [15:0] bits;
      bits = '0;
      for (int i = 0; i < n; i++) begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         bits = {bits[14:0], fb};
      end
      return bits;
   endfunction

   // ------------------------------
   // Host side
   // ------------------------------

   // Phi0 toggles every 8 CPU cycles
   always @(posedge cpu_clk) begin
      #1;
      if (phi_cnt == 7) begin
         phi_cnt = 0;
         phi_in  = ~phi_in;
      end else begin
         phi_cnt++;
      end
      bus_data_in = host_mem[bus_out.addr];
   end

   always @(posedge cpu_clk) begin
      cycles++;
      if (cycles >= timeout_cycles) begin
         $display("Error: no end of test after %0d cycles, the DUT stopped accepting", cycles);
         $display("TEST FAILED");
         $finish;
      end
   end

   // ------------------------------
   // Bus monitor and compare
   // ------------------------------
   always @(negedge cpu_clk) begin : compare_proc
      logic nxt_int;
      if (rst_n) begin
         if (bus_out.we) begin
            bus_seen = 1'b1;
         end
         // Host latches write data off the driven bus during Phi0 high
         if (phi_in && bus_out.we && bus_data_oe) begin
            host_mem[bus_out.addr] = bus_out.wdata;
         end
         assert (!(bus_data_oe && !(phi_in && bus_out.we)))
            else report_fail("data bus driven outside the Phi0 high half of a write");
         // Host clocks lag Phi0 by the output tap plus one
         assert ((phi2_out === phi_prev2) && (phi1_out === !phi_prev2))
            else report_fail("phi1_out or phi2_out out of step with phi_in");
         assert (!(bus_seen && phi_in && !bus_out.we && (bus_out.addr[15:8] < 8'h30)))
            else report_fail("host bus read cycle seen for a low RAM address");
         if (phi_in && !phi_prev && (bus_out.addr[15:8] >= 8'h80) &&
             (bus_out.addr[15:8] < 8'hC0)) begin
            rom_cycles++;
         end
         if (phi2_prev && !phi2_out) begin
            phi2_falls++;
         end
         assert (!(cpu_clken && !rdy)) else report_fail("cpu_clken high while rdy was low");
         if (cpu_clken) begin
            // Current access completes here
            if (cur_valid && !cur_m.we && (!cur_int_m || ram_valid[cur_m.addr])) begin
               expect_byte(test_name, predict_read(cur_m.addr, cur_int_m), cpu_di);
            end
            // Next access is routed on the state before this edge
            nxt_int = route_internal(cpu_req.addr);
            if (cpu_req.we && ram_write_allowed(cpu_req.addr)) begin
               ram_model[cpu_req.addr] = cpu_req.wdata;
               ram_valid[cpu_req.addr] = 1'b1;
            end
            if (cur_valid && cur_m.we && (cur_m.addr[15:2] == 14'h3F8C)) begin
               basic_m = (cur_m.wdata[3:0] == 4'd15);
            end
            if (cur_valid && cur_m.we && (cur_m.addr[15:2] == 14'h3F8D)) begin
               shadow_m = cur_m.wdata[7];
            end
            if (cur_valid && cur_m.sync) begin
               vdu_op_m = (cur_m.addr[15:8] >= 8'hC0) && (cur_m.addr[15:8] < 8'hE0);
            end
            cur_m     = cpu_req;
            cur_int_m = nxt_int;
            cur_valid = 1'b1;
         end
      end
      phi_prev2 = phi_prev;
      phi_prev  = phi_in;
      phi2_prev = phi2_out;
   end

   // ------------------------------
   // CPU model
   // ------------------------------
   task automatic wait_accept();
      do begin
         @(negedge cpu_clk);
      end while (!cpu_clken);
      @(posedge cpu_clk);
      #1;
   endtask

   // Returns once the access is taken and the previous one is complete
   task automatic issue(input addr_t a, input logic we, input data_t d, input logic sync);
      cpu_req = '{addr: a, wdata: d, we: we, sync: sync};
      wait_accept();
   endtask

   initial begin : stimulus
      logic [15:0] r;
      logic [15:0] w;
      logic [15:0] v;
      addr_t       a;
      addr_t       prev_a;
      data_t       d;
      data_t       prev_d;
      logic        prev_wr;
      int          snap;
      int          last;
      lfsr = 32'h0632_4566;
      rdy = 1'b1;
      phi_in = 1'b0;
      cpu_req = '0;
      bus_data_in = '0;
      errors = 0;
      checks = 0;
      cycles = 0;
      phi_cnt = 0;
      phi2_falls = 0;
      rom_cycles = 0;
      phi_prev = 1'b0;
      phi_prev2 = 1'b0;
      phi2_prev = 1'b0;
      bus_seen = 1'b0;
      basic_m = 1'b0;
      shadow_m = 1'b0;
      vdu_op_m = 1'b0;
      cur_m = '0;
      cur_int_m = 1'b1;
      cur_valid = 1'b0;
      prev_wr = 1'b0;
      prev_a = '0;
      prev_d = '0;
      for (int i = 0; i < 65536; i++) begin
         host_mem[i]  = fill_byte(addr_t'(i));
         ram_valid[i] = 1'b0;
      end
      @(posedge cpu_clk iff rst_n);
      #1;

      // Low RAM over a small address set so reads hit earlier writes
      test_name = "low_ram";
      for (int i = 0; i < 48; i++) begin
         r = next_bits(6);
         w = next_bits(1);
         v = next_bits(8);
         issue({5'b00010, r[5:3], 5'b00000, r[2:0]}, w[0], v[7:0], 1'b0);
      end

      // IO and paged ROM on the host
      test_name = "host_io";
      for (int i = 0; i < 24; i++) begin
         r = next_bits(2);
         v = next_bits(14);
         if (r[1:0] == 2'd0) begin
            a = {7'b1111110, v[8], v[7:0]};
         end else if (r[1:0] == 2'd1) begin
            a = {8'hFE, 1'b1, v[6:0]};
         end else begin
            a = {2'b10, v[13:0]};
         end
         w = next_bits(1);
         v = next_bits(8);
         d = host_mem[a] ^ (v[7:0] | 8'h01);
         issue(a, w[0], d, 1'b0);
         if (prev_wr) begin
            expect_byte("host_io write", prev_d, host_mem[prev_a]);
         end
         prev_wr = w[0];
         prev_a  = a;
         prev_d  = d;
      end
      issue(16'h1000, 1'b0, 8'h00, 1'b0);
      if (prev_wr) begin
         expect_byte("host_io write", prev_d, host_mem[prev_a]);
      end

      // With BASIC latched ROM reads stay local
      test_name = "basic_rom";
      issue(16'hFE30, 1'b1, 8'h0F, 1'b0);
      issue(16'h1001, 1'b0, 8'h00, 1'b0);
      issue(16'h1002, 1'b0, 8'h00, 1'b0);
      snap = rom_cycles;
      for (int i = 0; i < 6; i++) begin
         v = next_bits(14);
         issue({2'b10, v[13:0]}, 1'b0, 8'h00, 1'b0);
      end
      issue(16'h1003, 1'b0, 8'h00, 1'b0);
      issue(16'h1004, 1'b0, 8'h00, 1'b0);
      assert (rom_cycles == snap) else report_fail("bus cycle to a ROM page with BASIC latched");

      // Screen writes with shadow off are mirrored locally
      test_name = "screen_local";
      a = 16'h3300;
      issue(a, 1'b1, fill_byte(a) ^ 8'h5A, 1'b0);
      issue(a, 1'b0, 8'h00, 1'b0);
      issue(16'h1005, 1'b0, 8'h00, 1'b0);
      expect_byte("screen_local host", fill_byte(a), host_mem[a]);

      // With shadow on a VDU fetch sends screen writes out
      test_name = "screen_vdu";
      issue(16'hFE34, 1'b1, 8'h80, 1'b0);
      issue(16'hC123, 1'b0, 8'h00, 1'b1);
      issue(16'h1006, 1'b0, 8'h00, 1'b0);
      a = 16'h3100;
      d = fill_byte(a) ^ 8'h33;
      issue(a, 1'b1, d, 1'b0);
      issue(16'h1007, 1'b0, 8'h00, 1'b0);
      issue(16'h1008, 1'b0, 8'h00, 1'b0);
      expect_byte("screen_vdu host", d, host_mem[a]);

      // After a fetch from elsewhere the screen write stays local
      test_name = "screen_other";
      issue(16'h1234, 1'b0, 8'h00, 1'b1);
      issue(16'h1009, 1'b0, 8'h00, 1'b0);
      a = 16'h3200;
      issue(a, 1'b1, fill_byte(a) ^ 8'h66, 1'b0);
      issue(16'h100A, 1'b0, 8'h00, 1'b0);
      issue(16'h100B, 1'b0, 8'h00, 1'b0);
      expect_byte("screen_other host", fill_byte(a), host_mem[a]);
      issue(16'hFE34, 1'b1, 8'h00, 1'b0);

      // Long slowdown after a latch write with low bits zero
      test_name = "slowdown";
      issue(16'hFE40, 1'b1, 8'h00, 1'b0);
      issue(16'h100C, 1'b0, 8'h00, 1'b0);
      snap = phi2_falls;
      issue(16'h100D, 1'b0, 8'h00, 1'b0);
      assert (phi2_falls - snap >= 15)
         else report_fail($sformatf("internal access taken after %0d Phi2 falls",
                                    phi2_falls - snap));

      // Held rdy blocks every accept
      test_name = "rdy_hold";
      rdy = 1'b0;
      cpu_req = '{addr: 16'h100E, wdata: 8'h00, we: 1'b0, sync: 1'b0};
      repeat (40) @(posedge cpu_clk);
      #1 rdy = 1'b1;
      wait_accept();

      // Divider of 5 where the first interval may still follow the old count
      test_name = "speed_div";
      issue(16'hFE38, 1'b1, 8'd5, 1'b0);
      issue(16'h100F, 1'b0, 8'h00, 1'b0);
      issue(16'h1010, 1'b0, 8'h00, 1'b0);
      last = cycles;
      for (int i = 0; i < 8; i++) begin
         issue(16'h1011, 1'b0, 8'h00, 1'b0);
         if (i > 0) begin
            assert (cycles - last >= 5)
               else report_fail($sformatf("accesses only %0d cycles apart", cycles - last));
         end
         last = cycles;
      end
      issue(16'hFE38, 1'b1, 8'd1, 1'b0);
      issue(16'h1012, 1'b0, 8'h00, 1'b0);
      issue(16'h1013, 1'b0, 8'h00, 1'b0);

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

// ==== tb_clock_gen.sv ====
// ------------------------------
// Testbench clock and reset
// ------------------------------

`timescale 1ns/1ns

module tb_clock_gen #(
   parameter int period_ns    = 4,
   parameter int reset_cycles = 4
) (
   output logic cpu_clk,
   output logic rst_n
);

   initial begin
      cpu_clk = 1'b0;
      rst_n   = 1'b0;
      // Release just after an edge so the DUT sees a clean reset
      repeat (reset_cycles) @(posedge cpu_clk);
      #1 rst_n = 1'b1;
   end

   always #(period_ns / 2) cpu_clk = ~cpu_clk;

endmodule

// ==== beeb_accel_top.sv ====
// ------------------------------
// BBC Micro accelerator top
// ------------------------------

`timescale 1ns/1ns

module beeb_accel_top
   import accel_pkg::*;
#(
   parameter int nphi0_regs    = 6,
   parameter int phiout_tap    = 1,
   parameter int ram_addr_bits = 16
) (
   input  logic     cpu_clk,
   input  logic     rst_n,
   input  logic     phi_in,
   input  logic     rdy,
   input  cpu_req_t cpu_req,
   input  data_t    bus_data_in,
   output logic     cpu_clken,
   output data_t    cpu_di,
   output bus_out_t bus_out,
   output logic     bus_data_oe,
   output logic     phi1_out,
   output logic     phi2_out
);

   // Strobes from the Phi0 chain
   logic        ext_cycle_end;
   logic        capture_strobe;
   logic        tick;
   // Decoder outputs
   div_t        cpu_div;
   cpu_req_t    cur_req;
   logic        is_internal;
   logic        ram_wr_allow;
   // RAM ports
   data_t       ram_dout;
   data_t       scrub_dout;
   scrub_addr_t scrub_addr;

   // ------------------------------
   // Input side
   // ------------------------------
   phi_sync #(
      .nphi0_regs (nphi0_regs),
      .phiout_tap (phiout_tap)
   ) phi_sync_i (
      .cpu_clk        (cpu_clk),
      .rst_n          (rst_n),
      .phi_in         (phi_in),
      .cpu_div        (cpu_div),
      .phi1_out       (phi1_out),
      .phi2_out       (phi2_out),
      .ext_cycle_end  (ext_cycle_end),
      .capture_strobe (capture_strobe),
      .tick           (tick)
   );

   // ------------------------------
   // Decode and local RAM
   // ------------------------------
   access_decode access_decode_i (
      .cpu_clk      (cpu_clk),
      .rst_n        (rst_n),
      .cpu_req      (cpu_req),
      .cpu_clken    (cpu_clken),
      .cur_req      (cur_req),
      .is_internal  (is_internal),
      .ram_wr_allow (ram_wr_allow),
      .cpu_div      (cpu_div)
   );

   fast_ram #(
      .ram_addr_bits (ram_addr_bits)
   ) fast_ram_i (
      .cpu_clk      (cpu_clk),
      .cpu_clken    (cpu_clken),
      .cpu_req      (cpu_req),
      .ram_wr_allow (ram_wr_allow),
      .scrub_addr   (scrub_addr),
      .ram_dout     (ram_dout),
      .scrub_dout   (scrub_dout)
   );

   // ------------------------------
   // Output side
   // ------------------------------
   bus_sequencer bus_sequencer_i (
      .cpu_clk        (cpu_clk),
      .rst_n          (rst_n),
      .ext_cycle_end  (ext_cycle_end),
      .capture_strobe (capture_strobe),
      .tick           (tick),
      .rdy            (rdy),
      .is_internal    (is_internal),
      .cur_req        (cur_req),
      .ram_dout       (ram_dout),
      .scrub_dout     (scrub_dout),
      .bus_data_in    (bus_data_in),
      .phi_in         (phi_in),
      .scrub_addr     (scrub_addr),
      .bus_out        (bus_out),
      .bus_data_oe    (bus_data_oe),
      .cpu_clken      (cpu_clken),
      .cpu_di         (cpu_di)
   );

endmodule

// ==== bus_sequencer.sv ====
// ------------------------------
// Host bus cycle sequencer
// ------------------------------

`timescale 1ns/1ns

module bus_sequencer
   import accel_pkg::*;
(
   input  logic        cpu_clk,
   input  logic        rst_n,
   input  logic        ext_cycle_end,
   input  logic        capture_strobe,
   input  logic        tick,
   input  logic        rdy,
   input  logic        is_internal,
   input  cpu_req_t    cur_req,
   input  data_t       ram_dout,
   input  data_t       scrub_dout,
   input  data_t       bus_data_in,
   input  logic        phi_in,
   output scrub_addr_t scrub_addr,
   output bus_out_t    bus_out,
   output logic        bus_data_oe,
   output logic        cpu_clken,
   output data_t       cpu_di
);

   seq_state_t state;
   // One cycle after the chain edge
   logic       ext_cycle_start;
   // Remaining host-speed bus cycles
   logic [3:0] slowdown;
   // Host read data
   data_t      data_r;
   logic       is_sheila_wr;

   assign is_sheila_wr = cur_req.we && (cur_req.addr == sheila_latch_addr);

   // ------------------------------
   // Cycle start and slowdown
   // ------------------------------
   always_ff @(posedge cpu_clk) begin
      if (!rst_n) begin
         state           <= ext_idle_e;
         ext_cycle_start <= 1'b0;
         scrub_addr      <= '0;
         bus_out         <= '0;
         slowdown        <= '0;
      end else begin
         ext_cycle_start <= ext_cycle_end;
         if (ext_cycle_start) begin
            if (is_internal) begin
               // Bus is free, copy one local byte back to the host
               bus_out    <= '{addr: {1'b0, scrub_addr}, we: 1'b1, wdata: scrub_dout};
               state      <= ext_idle_e;
               scrub_addr <= scrub_addr + 1'b1;
            end else begin
               // CPU owns this host cycle
               bus_out <= '{addr: cur_req.addr, we: cur_req.we, wdata: cur_req.wdata};
               state   <= ext_busy_e;
            end
         end
         // Sound and keyboard need the latch strobe held at host speed
         // Sound wants ~9 us, keyboard far less
         if (ext_cycle_end) begin
            if (is_sheila_wr) begin
               slowdown <= (cur_req.wdata[2:0] == 3'b000) ? slow_long : slow_short;
            end else if (slowdown != '0) begin
               slowdown <= slowdown - 1'b1;
            end
         end
      end
   end

   // Sample on Phi2 falling at the output tap
   always_ff @(posedge cpu_clk) begin
      if (capture_strobe) begin
         data_r <= bus_data_in;
      end
   end

   // ------------------------------
   // CPU side
   // ------------------------------

   // Internal: next divider tick once slowdown is spent
   // External: end of the host cycle it owns
   assign cpu_clken = (is_internal && tick && (slowdown == '0) && rdy) ||
                      ((state == ext_busy_e) && ext_cycle_end && rdy);

   assign cpu_di = is_internal ? ram_dout : data_r;

   // Drive data only in the Phi2 half of a write
   assign bus_data_oe = bus_out.we & phi_in;

   // Slowdown must hold back internal accesses
   assert property (@(posedge cpu_clk) disable iff (!rst_n)
      (is_internal && (slowdown != '0)) |-> !cpu_clken);

endmodule

// ==== fast_ram.sv ====
// ------------------------------
// Local fast RAM
// ------------------------------

`timescale 1ns/1ns

module fast_ram
   import accel_pkg::*;
#(
   parameter int ram_addr_bits = 16
) (
   input  logic        cpu_clk,
   input  logic        cpu_clken,
   input  cpu_req_t    cpu_req,
   input  logic        ram_wr_allow,
   input  scrub_addr_t scrub_addr,
   output data_t       ram_dout,
   output data_t       scrub_dout
);

   // ------------------------------
   // Storage
   // ------------------------------
   data_t mem [0:(2**ram_addr_bits)-1];

   // Word indices into the array
   logic [ram_addr_bits-1:0] cpu_idx;
   logic [ram_addr_bits-1:0] scrub_idx;
   // Write qualifier
   logic                     cpu_wr;

   assign cpu_idx   = cpu_req.addr[ram_addr_bits-1:0];
   // Scrubber only walks the lower 32 KB
   assign scrub_idx = ram_addr_bits'(scrub_addr);

   // Only the lower 32 KB is writable
   // Screen area follows the mirror rule from the decoder
   assign cpu_wr = cpu_clken && cpu_req.we && !cpu_req.addr[15] && ram_wr_allow;

   // CPU port, works on the lookahead address
   always_ff @(posedge cpu_clk) begin
      if (cpu_wr) begin
         mem[cpu_idx] <= cpu_req.wdata;
      end
      if (cpu_clken) begin
         // Held until the access completes
         ram_dout <= mem[cpu_idx];
      end
   end

   // Scrub port, free running
   always_ff @(posedge cpu_clk) begin
      scrub_dout <= mem[scrub_idx];
   end

endmodule

// ==== access_decode.sv ====
// ------------------------------
// Latches and access lookahead
// ------------------------------

`timescale 1ns/1ns

module access_decode
   import accel_pkg::*;
(
   input  logic     cpu_clk,
   input  logic     rst_n,
   input  cpu_req_t cpu_req,
   input  logic     cpu_clken,
   output cpu_req_t cur_req,
   output logic     is_internal,
   output logic     ram_wr_allow,
   output div_t     cpu_div
);

   // Latch state
   logic  rom_latch_basic;
   logic  shadow;
   // Last opcode fetch came from the VDU driver area
   logic  vdu_op;

   // Decodes on the current access
   logic  is_rom_latch;
   logic  is_shadow_latch;
   logic  is_speed_latch;
   logic  cur_in_vdu;

   // Decodes on the next access
   page_t next_page;
   logic  is_shadow_latch_next;
   logic  is_speed_latch_next;
   logic  screen_ext;
   logic  screen_hit;
   logic  rom_hit;
   logic  io_hit;
   logic  is_internal_next;

   // ------------------------------
   // Current access decode
   // ------------------------------
   assign is_rom_latch    = (cur_req.addr[15:2] == rom_latch_addr);
   assign is_shadow_latch = (cur_req.addr[15:2] == shadow_latch_addr);
   assign is_speed_latch  = (cur_req.addr[15:2] == speed_latch_addr);
   assign cur_in_vdu      = (cur_req.addr[15:8] >= vdu_lo_page) &&
                            (cur_req.addr[15:8] <  vdu_hi_page);

   always_ff @(posedge cpu_clk) begin
      if (!rst_n) begin
         // Address 0 read, an internal access
         cur_req         <= '0;
         is_internal     <= 1'b1;
         rom_latch_basic <= 1'b0;
         shadow          <= 1'b0;
         cpu_div         <= '0;
         vdu_op          <= 1'b0;
      end else if (cpu_clken) begin
         // Latch writes complete with the current access
         if (cur_req.we) begin
            if (is_rom_latch) begin
               rom_latch_basic <= (cur_req.wdata[3:0] == basic_rom_slot);
            end
            if (is_shadow_latch) begin
               shadow <= cur_req.wdata[7];
            end
            if (is_speed_latch) begin
               // Stored as terminal count
               cpu_div <= cur_req.wdata[5:0] - 1'b1;
            end
         end
         // VDU driver lives in &C000-&DFFF of the MOS
         if (cur_req.sync) begin
            vdu_op <= cur_in_vdu;
         end
         // Take the next access
         cur_req     <= cpu_req;
         is_internal <= is_internal_next;
      end
   end

   // ------------------------------
   // Lookahead on the next access
   // ------------------------------
   assign next_page = cpu_req.addr[15:8];

   assign is_shadow_latch_next = (cpu_req.addr[15:2] == shadow_latch_addr);
   assign is_speed_latch_next  = (cpu_req.addr[15:2] == speed_latch_addr);

   // Shadow on: VDU code talks to the host's displayed bank
   // Shadow off: screen is mirrored locally and scrubbed out
   assign screen_ext = shadow & vdu_op;

   assign screen_hit = (next_page >= screen_lo_page) && (next_page < screen_hi_page) &&
                       screen_ext;
   // Sideways ROMs other than BASIC stay on the host
   assign rom_hit    = (next_page >= rom_lo_page) && (next_page < rom_hi_page) &&
                       !rom_latch_basic;
   // FRED, JIM and SHEILA
   assign io_hit     = (next_page >= io_lo_page) && (next_page < io_hi_page);

   // Own latches stay local, otherwise the host ROM latch gets trashed
   assign is_internal_next = !(screen_hit | rom_hit | io_hit) |
                             is_shadow_latch_next | is_speed_latch_next;

   // Low RAM always, screen only when it is not going out
   assign ram_wr_allow = (next_page < screen_lo_page) || !screen_ext;

endmodule

// ==== phi_sync.sv ====
// ------------------------------
// Phi0 sync and speed divider
// ------------------------------

`timescale 1ns/1ns

module phi_sync
   import accel_pkg::*;
#(
   parameter int nphi0_regs = 6,
   parameter int phiout_tap = 1
) (
   input  logic cpu_clk,
   input  logic rst_n,
   input  logic phi_in,
   input  div_t cpu_div,
   output logic phi1_out,
   output logic phi2_out,
   output logic ext_cycle_end,
   output logic capture_strobe,
   output logic tick
);

   // Delay chain, bit 0 is the newest sample
   logic [nphi0_regs-1:0] phi0_r;
   // Free running divider
   div_t                  clk_div;

   // ------------------------------
   // Phi0 delay chain
   // ------------------------------
   always_ff @(posedge cpu_clk) begin
      if (!rst_n) begin
         phi0_r <= '0;
      end else begin
         phi0_r <= {phi0_r[nphi0_regs-2:0], phi_in};
      end
   end

   // Host clocks taken from an early tap
   assign phi2_out = phi0_r[phiout_tap];
   assign phi1_out = !phi0_r[phiout_tap];

   // Phi2 falling at the output tap, host data is stable here
   assign capture_strobe = phi0_r[phiout_tap+1] & !phi0_r[phiout_tap];

   // Falling edge at the end of the chain
   // Late enough to give the host some address hold time
   assign ext_cycle_end = phi0_r[nphi0_regs-1] & !phi0_r[nphi0_regs-2];

   // ------------------------------
   // Speed divider
   // ------------------------------
   always_ff @(posedge cpu_clk) begin
      if (!rst_n) begin
         clk_div <= '0;
         tick    <= 1'b0;
      end else begin
         // Wrap also covers a divider lowered below the count
         if (clk_div >= cpu_div) begin
            clk_div <= '0;
         end else begin
            clk_div <= clk_div + 1'b1;
         end
         // Registered, one pulse per divider period
         tick <= (clk_div == '0);
      end
   end

   // Capture must land before the cycle ends, never on the same edge
   assert property (@(posedge cpu_clk) disable iff (!rst_n)
      !(ext_cycle_end && capture_strobe));

endmodule

// ==== accel_pkg.sv ====
// ------------------------------
// Accelerator shared definitions
// ------------------------------

package accel_pkg;

   // ------------------------------
   // Widths that carry a meaning
   // ------------------------------

   // CPU or host bus address
   typedef logic [15:0] addr_t;
   // One data byte
   typedef logic [7:0]  data_t;
   // High byte of an address
   typedef logic [7:0]  page_t;
   // Scrub pointer, lower 32 KB only
   typedef logic [14:0] scrub_addr_t;
   // Speed divider count
   typedef logic [5:0]  div_t;

   // Next access as presented by the CPU
   typedef struct packed {
      addr_t addr;
      data_t wdata;
      logic  we;
      logic  sync;
   } cpu_req_t;

   // Host bus drive
   typedef struct packed {
      addr_t addr;
      logic  we;
      data_t wdata;
   } bus_out_t;

   // External cycle owner
   typedef enum logic {
      ext_idle_e,
      ext_busy_e
   } seq_state_t;

   // ------------------------------
   // Latch decodes on addr[15:2]
   // ------------------------------

   // &FE30-&FE33 paged ROM select
   localparam logic [13:0] rom_latch_addr    = 14'h3F8C;
   // &FE34-&FE37 B+ shadow select
   localparam logic [13:0] shadow_latch_addr = 14'h3F8D;
   // &FE38-&FE3B speed divider
   localparam logic [13:0] speed_latch_addr  = 14'h3F8E;
   // System VIA port B, drives the addressable latch
   localparam addr_t       sheila_latch_addr = 16'hFE40;

   // ROM slot that holds BASIC on the B/B+
   localparam logic [3:0]  basic_rom_slot    = 4'd15;

   // Page ranges, low bound inclusive and high bound exclusive
   localparam page_t screen_lo_page = 8'h30;
   localparam page_t screen_hi_page = 8'h80;
   localparam page_t rom_lo_page    = 8'h80;
   localparam page_t rom_hi_page    = 8'hC0;
   localparam page_t vdu_lo_page    = 8'hC0;
   localparam page_t vdu_hi_page    = 8'hE0;
   localparam page_t io_lo_page     = 8'hFC;
   localparam page_t io_hi_page     = 8'hFF;

   // Bus cycles held at host speed after an addressable latch write
   localparam logic [3:0] slow_long  = 4'd15;
   localparam logic [3:0] slow_short = 4'd1;

endpackage
